/* build.f */
+incdir+logic
logic/decode_pkg.sv
logic/reg_file_bypass.sv
logic/alu_control.sv
logic/imm_decode.sv
logic/writeback_control.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv

/* logic/alu_control.sv */
`timescale 1ns/1ns

module alu_control (
	input  decode_pkg::opcode_e   opcode,
	input  logic [1:0]            func,
	output decode_pkg::alu_ctrl_t ctrl
);

	////////////////////////////////////////////////////////////////////////////
	// Opcode and function field decode.
	////////////////////////////////////////////////////////////////////////////

	// Instructions that do not use the ALU keep alusrc set, so they do not
	// report a use of the second register. No instruction inverts operand A.
	always_comb begin
		ctrl        = '0;
		ctrl.op     = decode_pkg::alu_add;
		ctrl.alusrc = 1'b1;

		case (opcode)
			decode_pkg::op_addi: begin
				ctrl.sign = 1'b1;
			end
			decode_pkg::op_subi: begin
				ctrl.inv_b = 1'b1;
				ctrl.cin   = 1'b1;
				ctrl.sign  = 1'b1;
			end
			decode_pkg::op_andi: begin
				ctrl.op = decode_pkg::alu_and;
			end
			decode_pkg::op_ori: begin
				ctrl.op = decode_pkg::alu_or;
			end
			decode_pkg::op_lui: begin
				ctrl.op = decode_pkg::alu_pass_b;
			end
			// Address generation is base register plus immediate.
			decode_pkg::op_st, decode_pkg::op_stu, decode_pkg::op_stb,
			decode_pkg::op_ld, decode_pkg::op_ldb: begin
				ctrl.op = decode_pkg::alu_add;
			end
			decode_pkg::op_rtype: begin
				ctrl.alusrc = 1'b0;
				case (func)
					2'b00: begin
						ctrl.op   = decode_pkg::alu_add;
						ctrl.sign = 1'b1;
					end
					2'b01: begin
						ctrl.op    = decode_pkg::alu_add;
						ctrl.inv_b = 1'b1;
						ctrl.cin   = 1'b1;
						ctrl.sign  = 1'b1;
					end
					2'b10:   ctrl.op = decode_pkg::alu_and;
					default: ctrl.op = decode_pkg::alu_or;
				endcase
			end
			default: begin
			end
		endcase
	end

	// The fetch side always presents a resolved instruction word, so an
	// unknown opcode points at an undriven or corrupted pipeline input.
	always_comb begin
		opcode_known_a: assert (!$isunknown(opcode))
			else $error("alu_control: opcode is unknown (%h)", opcode);
	end

endmodule

/* logic/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Width of one data word and of the instruction word.
`define DEC_DATA_W 32

// Number of architectural registers in the register file.
`define DEC_REG_COUNT 32

// Width of a register select field in the instruction.
`define DEC_REG_SEL_W 5

// Register written with the return address by jump-and-link.
`define DEC_LINK_REG 31

// Width of a memory byte mask, one bit per byte of a word.
`define DEC_BYTE_MASK_W 4

`endif

/* logic/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction opcodes, taken from bits 31 to 26 of the instruction word.
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [5:0] {
		op_nop   = 6'b000000,
		op_halt  = 6'b000001,
		op_j     = 6'b000100,
		op_jal   = 6'b000110,
		op_addi  = 6'b001000,
		op_subi  = 6'b001001,
		op_andi  = 6'b001010,
		op_ori   = 6'b001011,
		op_lui   = 6'b001111,
		op_st    = 6'b010000,
		op_ld    = 6'b010001,
		op_stu   = 6'b010011,
		op_rtype = 6'b011011,
		op_ldb   = 6'b110000,
		op_stb   = 6'b111000
	} opcode_e;

	// Operations the execute stage ALU can perform.
	// Subtraction is an add with operand B inverted and a carry in.
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_and    = 4'h1,
		alu_or     = 4'h2,
		alu_xor    = 4'h3,
		alu_pass_b = 4'h4,
		alu_sll    = 4'h5
	} alu_op_e;

	// Source of the value written back to the register file.
	typedef enum logic [1:0] {
		wb_alu  = 2'b00,
		wb_mem  = 2'b01,
		wb_link = 2'b10
	} wb_src_e;

	////////////////////////////////////////////////////////////////////////////
	// Grouped control and data bundles.
	////////////////////////////////////////////////////////////////////////////

	// Register file write from the writeback stage.
	typedef struct packed {
		logic [`DEC_DATA_W-1:0]    data;
		logic [`DEC_REG_SEL_W-1:0] sel;
		logic                      en;
	} reg_write_t;

	// Controls for the execute stage ALU.
	typedef struct packed {
		alu_op_e op;
		logic    inv_a;
		logic    inv_b;
		logic    cin;
		logic    sign;
		logic    alusrc;
	} alu_ctrl_t;

	// Memory stage byte masks and read strobe.
	typedef struct packed {
		logic [`DEC_BYTE_MASK_W-1:0] write;
		logic                        read;
		logic [`DEC_BYTE_MASK_W-1:0] enable;
	} mem_ctrl_t;

	// Writeback destination and data source.
	typedef struct packed {
		wb_src_e                   src;
		logic [`DEC_REG_SEL_W-1:0] reg_sel;
		logic                      en;
	} wb_ctrl_t;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/1ns

`include "decode_params.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`DEC_DATA_W-1:0] instr,
	input  logic                   save_regs,
	input  logic                   restore_regs,
	input  decode_pkg::reg_write_t wr,
	output logic [`DEC_DATA_W-1:0] read1_data,
	output logic [`DEC_DATA_W-1:0] read2_data,
	output decode_pkg::alu_ctrl_t  alu_ctrl,
	output logic [`DEC_DATA_W-1:0] imm_value,
	output decode_pkg::mem_ctrl_t  mem_ctrl,
	output decode_pkg::wb_ctrl_t   wb_ctrl,
	output logic                   reg2_used
);

	decode_pkg::opcode_e         opcode;
	logic [`DEC_REG_SEL_W-1:0]   rs_sel;
	logic [`DEC_REG_SEL_W-1:0]   rt_sel;
	logic [`DEC_BYTE_MASK_W-1:0] mem_write;
	logic [`DEC_BYTE_MASK_W-1:0] mem_rd_mask;

	assign opcode = decode_pkg::opcode_e'(instr[31:26]);
	assign rs_sel = instr[25:21];
	assign rt_sel = instr[20:16];

	////////////////////////////////////////////////////////////////////////////
	// Memory control.
	////////////////////////////////////////////////////////////////////////////

	// Word accesses use all four byte lanes, byte accesses only the lowest.
	always_comb begin
		mem_write = '0;
		case (opcode)
			decode_pkg::op_st, decode_pkg::op_stu: mem_write = 4'b1111;
			decode_pkg::op_stb:                    mem_write = 4'b0001;
			default: begin
			end
		endcase
	end

	// Loads are decoded in a table of their own.
	always_comb begin
		mem_rd_mask = '0;
		case (opcode)
			decode_pkg::op_ld:  mem_rd_mask = 4'b1111;
			decode_pkg::op_ldb: mem_rd_mask = 4'b0001;
			default: begin
			end
		endcase
	end

	assign mem_ctrl.write  = mem_write;
	assign mem_ctrl.read   = |mem_rd_mask;
	assign mem_ctrl.enable = mem_write | mem_rd_mask;

	// Stores read rt as data, register-operand instructions read it as B.
	assign reg2_used = (mem_write != '0) | ~alu_ctrl.alusrc;

	////////////////////////////////////////////////////////////////////////////
	// Sub-blocks.
	////////////////////////////////////////////////////////////////////////////

	reg_file_bypass reg_file_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd1_sel  (rs_sel),
		.rd2_sel  (rt_sel),
		.wr       (wr),
		.save     (save_regs),
		.restore  (restore_regs),
		.rd1_data (read1_data),
		.rd2_data (read2_data)
	);

	alu_control alu_control_i (
		.opcode (opcode),
		.func   (instr[1:0]),
		.ctrl   (alu_ctrl)
	);

	imm_decode imm_decode_i (
		.instr     (instr),
		.imm_value (imm_value)
	);

	writeback_control writeback_control_i (
		.instr (instr),
		.ctrl  (wb_ctrl)
	);

	// The memory stage has a single access path, so the store and load
	// tables must never claim the same opcode.
	mem_read_write_exclusive_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(mem_ctrl.read && (mem_ctrl.write != '0))
	) else $error("decode_stage: read and write decoded together (write %h)",
		mem_ctrl.write);

endmodule

/* logic/imm_decode.sv */
`timescale 1ns/1ns

`include "decode_params.svh"

module imm_decode (
	input  logic [`DEC_DATA_W-1:0] instr,
	output logic [`DEC_DATA_W-1:0] imm_value
);

	decode_pkg::opcode_e opcode;
	logic [15:0]         imm16;
	logic [25:0]         off26;

	assign opcode = decode_pkg::opcode_e'(instr[31:26]);
	assign imm16  = instr[15:0];
	assign off26  = instr[25:0];

	// Arithmetic and address offsets are signed, logic immediates are not.
	always_comb begin
		case (opcode)
			decode_pkg::op_addi, decode_pkg::op_subi,
			decode_pkg::op_st, decode_pkg::op_stu, decode_pkg::op_stb,
			decode_pkg::op_ld, decode_pkg::op_ldb: begin
				imm_value = {{(`DEC_DATA_W-16){imm16[15]}}, imm16};
			end
			decode_pkg::op_andi, decode_pkg::op_ori: begin
				imm_value = {{(`DEC_DATA_W-16){1'b0}}, imm16};
			end
			decode_pkg::op_lui: begin
				imm_value = {imm16, {(`DEC_DATA_W-16){1'b0}}};
			end
			// Jump offsets span the whole field below the opcode.
			decode_pkg::op_j, decode_pkg::op_jal: begin
				imm_value = {{(`DEC_DATA_W-26){off26[25]}}, off26};
			end
			default: begin
				imm_value = '0;
			end
		endcase
	end

endmodule

/* logic/reg_file_bypass.sv */
`timescale 1ns/1ns

`include "decode_params.svh"

module reg_file_bypass (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`DEC_REG_SEL_W-1:0] rd1_sel,
	input  logic [`DEC_REG_SEL_W-1:0] rd2_sel,
	input  decode_pkg::reg_write_t    wr,
	input  logic                      save,
	input  logic                      restore,
	output logic [`DEC_DATA_W-1:0]    rd1_data,
	output logic [`DEC_DATA_W-1:0]    rd2_data
);

	// Architectural registers and the single shadow copy.
	logic [`DEC_DATA_W-1:0] regs   [`DEC_REG_COUNT];
	logic [`DEC_DATA_W-1:0] shadow [`DEC_REG_COUNT];

	logic bypass1;
	logic bypass2;

	////////////////////////////////////////////////////////////////////////////
	// Register array update.
	////////////////////////////////////////////////////////////////////////////

	// A restore reloads every register from the shadow and drops any write
	// presented in the same cycle. Register 0 is an ordinary storage slot.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DEC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (restore) begin
			for (int i = 0; i < `DEC_REG_COUNT; i++) begin
				regs[i] <= shadow[i];
			end
		end else if (wr.en) begin
			regs[wr.sel] <= wr.data;
		end
	end

	// The shadow captures the registers as they stand before this edge,
	// so a write in the save cycle is not part of the snapshot.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DEC_REG_COUNT; i++) begin
				shadow[i] <= '0;
			end
		end else if (save) begin
			for (int i = 0; i < `DEC_REG_COUNT; i++) begin
				shadow[i] <= regs[i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports.
	////////////////////////////////////////////////////////////////////////////

	// A pending write to the selected register is forwarded in the same cycle.
	assign bypass1 = wr.en && (wr.sel == rd1_sel);
	assign bypass2 = wr.en && (wr.sel == rd2_sel);

	assign rd1_data = bypass1 ? wr.data : regs[rd1_sel];
	assign rd2_data = bypass2 ? wr.data : regs[rd2_sel];

	// The exception controller never saves and restores in one cycle.
	// Doing so would leave the shadow content undefined for the next restore.
	save_restore_exclusive_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(save && restore)
	) else $error("reg_file_bypass: save and restore asserted in the same cycle");

endmodule

/* logic/writeback_control.sv */
`timescale 1ns/1ns

`include "decode_params.svh"

module writeback_control (
	input  logic [`DEC_DATA_W-1:0] instr,
	output decode_pkg::wb_ctrl_t   ctrl
);

	decode_pkg::opcode_e       opcode;
	logic [`DEC_REG_SEL_W-1:0] rs;
	logic [`DEC_REG_SEL_W-1:0] rt;
	logic [`DEC_REG_SEL_W-1:0] rd;

	assign opcode = decode_pkg::opcode_e'(instr[31:26]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// Instructions that write no register leave both the enable and the
	// select at zero.
	always_comb begin
		ctrl     = '0;
		ctrl.src = decode_pkg::wb_alu;

		case (opcode)
			decode_pkg::op_rtype: begin
				ctrl.reg_sel = rd;
				ctrl.en      = 1'b1;
			end
			decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_andi,
			decode_pkg::op_ori, decode_pkg::op_lui: begin
				ctrl.reg_sel = rt;
				ctrl.en      = 1'b1;
			end
			decode_pkg::op_ld, decode_pkg::op_ldb: begin
				ctrl.reg_sel = rt;
				ctrl.en      = 1'b1;
				ctrl.src     = decode_pkg::wb_mem;
			end
			// Store with update writes the new address back to its base.
			decode_pkg::op_stu: begin
				ctrl.reg_sel = rs;
				ctrl.en      = 1'b1;
			end
			decode_pkg::op_jal: begin
				ctrl.reg_sel = `DEC_REG_SEL_W'(`DEC_LINK_REG);
				ctrl.en      = 1'b1;
				ctrl.src     = decode_pkg::wb_link;
			end
			default: begin
			end
		endcase
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module decode_stage_tb -f build.f -o decode_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0

/* verif/decode_stage_tb.sv */
`timescale 1ns/1ns

`include "decode_params.svh"

module decode_stage_tb;

	// Six tests of at most 200 cycles each, with margin for resets and idles.
	localparam int test_count  = 6;
	localparam int test_cycles = 200;
	localparam int cycle_limit = test_count * test_cycles + 800;

	// Every defined opcode plus one that the ISA leaves unused.
	localparam logic [5:0] opcode_table [16] = '{
		decode_pkg::op_nop, decode_pkg::op_halt, decode_pkg::op_j, decode_pkg::op_jal,
		decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_andi, decode_pkg::op_ori,
		decode_pkg::op_lui, decode_pkg::op_st, decode_pkg::op_ld, decode_pkg::op_stu,
		decode_pkg::op_rtype, decode_pkg::op_ldb, decode_pkg::op_stb, 6'h3f
	};

	logic                   clk;
	logic                   rst_n;
	logic [`DEC_DATA_W-1:0] instr;
	logic                   save_regs;
	logic                   restore_regs;
	decode_pkg::reg_write_t wr;
	logic [`DEC_DATA_W-1:0] read1_data;
	logic [`DEC_DATA_W-1:0] read2_data;
	decode_pkg::alu_ctrl_t  alu_ctrl;
	logic [`DEC_DATA_W-1:0] imm_value;
	decode_pkg::mem_ctrl_t  mem_ctrl;
	decode_pkg::wb_ctrl_t   wb_ctrl;
	logic                   reg2_used;

	// Register and shadow model, plus the expected DUT outputs.
	logic [`DEC_DATA_W-1:0] model_regs   [`DEC_REG_COUNT];
	logic [`DEC_DATA_W-1:0] model_shadow [`DEC_REG_COUNT];
	logic [`DEC_DATA_W-1:0] exp_rd1;
	logic [`DEC_DATA_W-1:0] exp_rd2;
	decode_pkg::alu_ctrl_t  exp_alu;
	logic [`DEC_DATA_W-1:0] exp_imm;
	decode_pkg::mem_ctrl_t  exp_mem;
	decode_pkg::wb_ctrl_t   exp_wb;
	logic                   exp_reg2;

	int error_count;
	int test_start_errors;
	int test_number;
	int failed_tests;
	int cycle_count;

	decode_stage dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.save_regs    (save_regs),
		.restore_regs (restore_regs),
		.wr           (wr),
		.read1_data   (read1_data),
		.read2_data   (read2_data),
		.alu_ctrl     (alu_ctrl),
		.imm_value    (imm_value),
		.mem_ctrl     (mem_ctrl),
		.wb_ctrl      (wb_ctrl),
		.reg2_used    (reg2_used)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference decode rules.
	////////////////////////////////////////////////////////////////////////////

	function automatic decode_pkg::alu_ctrl_t decode_alu(input logic [`DEC_DATA_W-1:0] ins);
		decode_pkg::alu_ctrl_t c;
		decode_pkg::opcode_e   op;
		logic                  rtype;
		logic                  is_sub;
		op     = decode_pkg::opcode_e'(ins[31:26]);
		rtype  = (op == decode_pkg::op_rtype);
		is_sub = (op == decode_pkg::op_subi) || (rtype && ins[1:0] == 2'b01);
		c        = '0;
		c.op     = decode_pkg::alu_add;
		c.alusrc = !rtype;
		if (op == decode_pkg::op_andi || (rtype && ins[1:0] == 2'b10)) begin
			c.op = decode_pkg::alu_and;
		end
		if (op == decode_pkg::op_ori || (rtype && ins[1:0] == 2'b11)) begin
			c.op = decode_pkg::alu_or;
		end
		if (op == decode_pkg::op_lui) begin
			c.op = decode_pkg::alu_pass_b;
		end
		c.inv_b = is_sub;
		c.cin   = is_sub;
		c.sign  = is_sub || (op == decode_pkg::op_addi) || (rtype && ins[1:0] == 2'b00);
		return c;
	endfunction

	function automatic logic [`DEC_DATA_W-1:0] extend_imm(input logic [`DEC_DATA_W-1:0] ins);
		decode_pkg::opcode_e op;
		op = decode_pkg::opcode_e'(ins[31:26]);
		case (op)
			decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_ld, decode_pkg::op_ldb,
			decode_pkg::op_st, decode_pkg::op_stu, decode_pkg::op_stb:
				return 32'($signed(ins[15:0]));
			decode_pkg::op_andi, decode_pkg::op_ori:
				return {16'h0000, ins[15:0]};
			decode_pkg::op_lui:
				return {ins[15:0], 16'h0000};
			decode_pkg::op_j, decode_pkg::op_jal:
				return 32'($signed(ins[25:0]));
			default:
				return '0;
		endcase
	endfunction

	function automatic decode_pkg::mem_ctrl_t mem_masks(input logic [`DEC_DATA_W-1:0] ins);
		decode_pkg::mem_ctrl_t m;
		decode_pkg::opcode_e   op;
		logic [3:0]            rmask;
		op      = decode_pkg::opcode_e'(ins[31:26]);
		m       = '0;
		rmask   = 4'h0;
		if (op == decode_pkg::op_st || op == decode_pkg::op_stu) begin
			m.write = 4'hf;
		end
		if (op == decode_pkg::op_stb) begin
			m.write = 4'h1;
		end
		if (op == decode_pkg::op_ld) begin
			rmask = 4'hf;
		end
		if (op == decode_pkg::op_ldb) begin
			rmask = 4'h1;
		end
		m.read   = (rmask != 4'h0);
		m.enable = m.write | rmask;
		return m;
	endfunction

	function automatic logic second_reg_used(input logic [`DEC_DATA_W-1:0] ins);
		decode_pkg::mem_ctrl_t m;
		decode_pkg::alu_ctrl_t a;
		m = mem_masks(ins);
		a = decode_alu(ins);
		return (m.write != 4'h0) || !a.alusrc;
	endfunction

	function automatic decode_pkg::wb_ctrl_t wb_target(input logic [`DEC_DATA_W-1:0] ins);
		decode_pkg::wb_ctrl_t c;
		decode_pkg::opcode_e  op;
		op = decode_pkg::opcode_e'(ins[31:26]);
		c  = '0;
		case (op)
			decode_pkg::op_rtype: c.reg_sel = ins[15:11];
			decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_andi, decode_pkg::op_ori,
			decode_pkg::op_lui, decode_pkg::op_ld, decode_pkg::op_ldb: c.reg_sel = ins[20:16];
			decode_pkg::op_stu: c.reg_sel = ins[25:21];
			decode_pkg::op_jal: c.reg_sel = `DEC_REG_SEL_W'(`DEC_LINK_REG);
			default: c.reg_sel = '0;
		endcase
		c.en  = (op == decode_pkg::op_rtype) || (op == decode_pkg::op_addi) ||
			(op == decode_pkg::op_subi) || (op == decode_pkg::op_andi) ||
			(op == decode_pkg::op_ori) || (op == decode_pkg::op_lui) ||
			(op == decode_pkg::op_ld) || (op == decode_pkg::op_ldb) ||
			(op == decode_pkg::op_stu) || (op == decode_pkg::op_jal);
		c.src = decode_pkg::wb_alu;
		if (op == decode_pkg::op_ld || op == decode_pkg::op_ldb) begin
			c.src = decode_pkg::wb_mem;
		end
		if (op == decode_pkg::op_jal) begin
			c.src = decode_pkg::wb_link;
		end
		return c;
	endfunction

	// The model follows the same edge rules as the register file, with a
	// restore dropping a write in the same cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DEC_REG_COUNT; i++) begin
				model_regs[i]   <= '0;
				model_shadow[i] <= '0;
			end
		end else begin
			if (save_regs) begin
				for (int i = 0; i < `DEC_REG_COUNT; i++) begin
					model_shadow[i] <= model_regs[i];
				end
			end
			if (restore_regs) begin
				for (int i = 0; i < `DEC_REG_COUNT; i++) begin
					model_regs[i] <= model_shadow[i];
				end
			end else if (wr.en) begin
				model_regs[wr.sel] <= wr.data;
			end
		end
	end

	always_comb begin
		exp_rd1 = model_regs[instr[25:21]];
		exp_rd2 = model_regs[instr[20:16]];
		if (wr.en && wr.sel == instr[25:21]) begin
			exp_rd1 = wr.data;
		end
		if (wr.en && wr.sel == instr[20:16]) begin
			exp_rd2 = wr.data;
		end
	end

	assign exp_alu  = decode_alu(instr);
	assign exp_imm  = extend_imm(instr);
	assign exp_mem  = mem_masks(instr);
	assign exp_wb   = wb_target(instr);
	assign exp_reg2 = second_reg_used(instr);

	////////////////////////////////////////////////////////////////////////////
	// Output checks.
	////////////////////////////////////////////////////////////////////////////

	read1_a: assert property (@(posedge clk) disable iff (!rst_n) read1_data == exp_rd1)
		else begin
			error_count = error_count + 1;
			$display("Error: read1_data is %h, expected %h", $sampled(read1_data),
				$sampled(exp_rd1));
		end

	read2_a: assert property (@(posedge clk) disable iff (!rst_n) read2_data == exp_rd2)
		else begin
			error_count = error_count + 1;
			$display("Error: read2_data is %h, expected %h", $sampled(read2_data),
				$sampled(exp_rd2));
		end

	alu_ctrl_a: assert property (@(posedge clk) disable iff (!rst_n) alu_ctrl == exp_alu)
		else begin
			error_count = error_count + 1;
			$display("Error: alu_ctrl is %h, expected %h (instr %h)", $sampled(alu_ctrl),
				$sampled(exp_alu), $sampled(instr));
		end

	imm_value_a: assert property (@(posedge clk) disable iff (!rst_n) imm_value == exp_imm)
		else begin
			error_count = error_count + 1;
			$display("Error: imm_value is %h, expected %h (instr %h)", $sampled(imm_value),
				$sampled(exp_imm), $sampled(instr));
		end

	mem_ctrl_a: assert property (@(posedge clk) disable iff (!rst_n) mem_ctrl == exp_mem)
		else begin
			error_count = error_count + 1;
			$display("Error: mem_ctrl is %h, expected %h (instr %h)", $sampled(mem_ctrl),
				$sampled(exp_mem), $sampled(instr));
		end

	wb_ctrl_a: assert property (@(posedge clk) disable iff (!rst_n) wb_ctrl == exp_wb)
		else begin
			error_count = error_count + 1;
			$display("Error: wb_ctrl is %h, expected %h (instr %h)", $sampled(wb_ctrl),
				$sampled(exp_wb), $sampled(instr));
		end

	reg2_used_a: assert property (@(posedge clk) disable iff (!rst_n) reg2_used == exp_reg2)
		else begin
			error_count = error_count + 1;
			$display("Error: reg2_used is %h, expected %h (instr %h)", $sampled(reg2_used),
				$sampled(exp_reg2), $sampled(instr));
		end

	// A nop leaves every memory lane, write flag and register use inactive.
	nop_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
		(instr[31:26] == decode_pkg::op_nop) |->
		(mem_ctrl == '0 && !wb_ctrl.en && !reg2_used))
		else begin
			error_count = error_count + 1;
			$display("Error: nop decoded with activity, mem_ctrl %h wb_ctrl %h reg2_used %h",
				$sampled(mem_ctrl), $sampled(wb_ctrl), $sampled(reg2_used));
		end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus.
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_cycle(input logic [`DEC_DATA_W-1:0] ins,
		input decode_pkg::reg_write_t w, input logic save, input logic restore);
		@(posedge clk);
		instr        <= ins;
		wr           <= w;
		save_regs    <= save;
		restore_regs <= restore;
	endtask

	task automatic finish_test(input string name);
		int mismatches;
		drive_cycle('0, '0, 1'b0, 1'b0);
		@(negedge clk);
		mismatches  = error_count - test_start_errors;
		test_number = test_number + 1;
		if (mismatches == 0) begin
			$display("Test %0d, %s: passed", test_number, name);
		end else begin
			failed_tests = failed_tests + 1;
			$display("Test %0d, %s: failed with %0d mismatches", test_number, name, mismatches);
		end
		test_start_errors = error_count;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n        <= 1'b0;
		instr        <= '0;
		wr           <= '0;
		save_regs    <= 1'b0;
		restore_regs <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: the tests did not complete within %0d cycles", cycle_limit);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		decode_pkg::reg_write_t w;
		void'($urandom(32'he1db));
		error_count       = 0;
		test_start_errors = 0;
		test_number       = 0;
		failed_tests      = 0;
		rst_n             = 1'b0;
		instr             = '0;
		wr                = '0;
		save_regs         = 1'b0;
		restore_regs      = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Each write is read back in its own cycle through the bypass.
		for (int i = 0; i < `DEC_REG_COUNT; i++) begin
			w = {32'($urandom()), 5'(i), 1'b1};
			drive_cycle({decode_pkg::op_rtype, 5'(i), 5'(31 - i), 16'($urandom())}, w, 0, 0);
		end
		for (int i = 0; i < `DEC_REG_COUNT; i++) begin
			drive_cycle({decode_pkg::op_rtype, 5'(i), 5'(31 - i), 16'($urandom())}, '0, 0, 0);
		end
		finish_test("register writes and bypass");

		drive_cycle('0, '0, 1'b1, 1'b0);
		for (int i = 0; i < `DEC_REG_COUNT; i++) begin
			w = {32'($urandom()), 5'(i), 1'b1};
			drive_cycle({decode_pkg::op_addi, 5'(i), 5'(i), 16'($urandom())}, w, 0, 0);
		end
		w = {32'($urandom()), 5'd5, 1'b1};
		drive_cycle({decode_pkg::op_rtype, 5'd5, 5'd6, 16'h0000}, w, 1'b0, 1'b1);
		for (int i = 0; i < `DEC_REG_COUNT / 2; i++) begin
			drive_cycle({decode_pkg::op_rtype, 5'(2 * i), 5'(2 * i + 1), 16'h0000}, '0, 0, 0);
		end
		finish_test("shadow save and restore");

		for (int k = 0; k < 16; k++) begin
			for (int f = 0; f < 4; f++) begin
				drive_cycle({opcode_table[k], 24'($urandom()), 2'(f)}, '0, 0, 0);
			end
		end
		finish_test("ALU control decode");

		for (int k = 0; k < 16; k++) begin
			repeat (8) drive_cycle({opcode_table[k], 26'($urandom())}, '0, 0, 0);
		end
		finish_test("immediate decode");

		for (int k = 0; k < 16; k++) begin
			drive_cycle({opcode_table[k], 26'($urandom())}, '0, 0, 0);
		end
		apply_reset();
		drive_cycle('0, '0, 1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_cycle({6'b000000, 5'(i), 5'(31 - i), 16'h0000}, '0, 0, 0);
		end
		finish_test("memory control and reset state");

		for (int k = 0; k < 16; k++) begin
			repeat (8) drive_cycle({opcode_table[k], 26'($urandom())}, '0, 0, 0);
		end
		finish_test("writeback control decode");

		$display("Summary: %0d tests run, %0d failed, %0d mismatches", test_number,
			failed_tests, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
